// File: sim/dcache_cases.txt
# op (0 load, 1 store, 2 flush)  address  write data  expected read data  expected hit
# all columns in hex
0 00000104 00000000 5A5A0041 0
0 00000104 00000000 5A5A0041 1
0 0000010C 00000000 5A5A0043 1
1 00000108 CAFE0001 00000000 1
0 00000108 00000000 CAFE0001 1
2 00000100 00000000 00000000 1
0 00000108 00000000 CAFE0001 0
0 00000100 00000000 5A5A0040 1
0 00001020 00000000 5A5A0408 0
0 00002024 00000000 5A5A0809 0
0 00001028 00000000 5A5A040A 0
1 0000202C 1234ABCD 00000000 0
0 0000202C 00000000 1234ABCD 1
0 00002020 00000000 5A5A0808 1
0 0000102C 00000000 5A5A040B 0
0 0000202C 00000000 1234ABCD 0
1 80000F3C 0BADF00D 00000000 0
0 80000F30 00000000 7A5A03CC 1
2 80000F30 00000000 00000000 1
0 80000F3C 00000000 0BADF00D 0

// File: vlog.f
verilog/dcache_pkg.sv
verilog/dcache_array.sv
verilog/dcache_replacer.sv
verilog/dcache_controller.sv
verilog/dcache_top.sv
sim/line_memory_model.sv
sim/dcache_tb.sv

// File: Makefile
TOOL       := verilator
TOP        := dcache_tb
FILELIST   := vlog.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
PASS_TEXT  := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: sim/dcache_tb.sv
// ====================
// Data cache testbench
// Runs the access cases from the case file against the cache
// and a behavioural line memory
// ====================
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

    localparam int    INDEX_WIDTH     = 4;
    localparam int    OFFSET_WIDTH    = 2;
    localparam int    LINE_ADDR_WIDTH = dcache_pkg::ADDR_WIDTH - OFFSET_WIDTH - 2;
    localparam int    LINE_WIDTH      = dcache_pkg::WORD_WIDTH * (2 ** OFFSET_WIDTH);
    localparam int    RESET_CYCLES    = 8;
    localparam int    CYCLES_PER_CASE = 40;
    localparam string CASE_FILE       = "sim/dcache_cases.txt";

    typedef struct packed {
        dcache_pkg::cpu_op_t op;
        logic [31:0]         addr;
        logic [31:0]         wdata;
        logic [31:0]         rdata;
        logic                hit;
    } access_case_t;

    logic                  clk;
    logic                  rst;
    logic                  req_valid;
    dcache_pkg::cpu_req_t  req;
    logic                  busy;
    logic                  resp_valid;
    dcache_pkg::cpu_resp_t resp;

    logic [LINE_ADDR_WIDTH-1:0]              mem_addr;
    logic                                    mem_read_enable;
    logic                                    mem_write_enable;
    logic [LINE_WIDTH-1:0]                   mem_write_line;
    logic                                    mem_read_done;
    logic                                    mem_write_done;
    logic [LINE_WIDTH-1:0]                   mem_read_line;
    logic [LINE_ADDR_WIDTH+OFFSET_WIDTH-1:0] peek_addr;
    logic [31:0]                             peek_data;
    int                                      read_count;
    int                                      write_count;

    access_case_t cases[$];
    int           errors      = 0;
    int           cycles      = 0;
    int           cycle_limit = 0;

    dcache_top #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) UUT (
        .clk              (clk),
        .rst              (rst),
        .req_valid        (req_valid),
        .req              (req),
        .busy             (busy),
        .resp_valid       (resp_valid),
        .resp             (resp),
        .mem_addr         (mem_addr),
        .mem_read_enable  (mem_read_enable),
        .mem_write_enable (mem_write_enable),
        .mem_write_line   (mem_write_line),
        .mem_read_done    (mem_read_done),
        .mem_write_done   (mem_write_done),
        .mem_read_line    (mem_read_line)
    );

    line_memory_model #(
        .LINE_ADDR_WIDTH (LINE_ADDR_WIDTH),
        .OFFSET_WIDTH    (OFFSET_WIDTH)
    ) memory (
        .clk          (clk),
        .rst          (rst),
        .addr         (mem_addr),
        .read_enable  (mem_read_enable),
        .write_enable (mem_write_enable),
        .write_line   (mem_write_line),
        .read_done    (mem_read_done),
        .write_done   (mem_write_done),
        .read_line    (mem_read_line),
        .peek_addr    (peek_addr),
        .peek_data    (peek_data),
        .read_count   (read_count),
        .write_count  (write_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the cache gave no response within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // A miss other than a flush fetches exactly one line
    function automatic logic [31:0] expected_reads(input access_case_t c);
        return (c.op != dcache_pkg::OP_FLUSH && !c.hit) ? 32'd1 : 32'd0;
    endfunction

    // Every store writes its line through
    function automatic logic [31:0] expected_writes(input access_case_t c);
        return (c.op == dcache_pkg::OP_STORE) ? 32'd1 : 32'd0;
    endfunction

    task automatic read_cases(output bit loaded);
        int           fd;
        int           fields;
        string        line;
        logic [31:0]  op_code;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        logic [31:0]  rdata;
        logic [31:0]  hit;
        access_case_t c;
        fd = $fopen(CASE_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h", op_code, addr, wdata, rdata, hit);
                    if (fields == 5) begin
                        c.op    = dcache_pkg::cpu_op_t'(op_code[1:0]);
                        c.addr  = addr;
                        c.wdata = wdata;
                        c.rdata = rdata;
                        c.hit   = hit[0];
                        cases.push_back(c);
                    end
                end
            end
            $fclose(fd);
        end
        loaded = (cases.size() > 0);
    endtask

    task automatic run_case(input int n, input access_case_t c);
        string name;
        int    reads_before;
        int    writes_before;
        name = $sformatf("case %0d", n + 1);
        @(posedge clk);
        #1;
        while (busy) begin
            @(posedge clk);
            #1;
        end
        reads_before  = read_count;
        writes_before = write_count;
        req_valid = 1'b1;
        req.op    = c.op;
        req.addr  = c.addr;
        req.wdata = c.wdata;
        peek_addr = c.addr[31:2];
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        // Busy rises on the cycle after acceptance
        check_value({name, " busy"}, 32'd1, 32'(busy));
        while (!resp_valid) begin
            @(posedge clk);
            #1;
        end
        check_value({name, " data"}, c.rdata, resp.rdata);
        check_value({name, " hit"}, 32'(c.hit), 32'(resp.hit));
        check_value({name, " memory reads"}, expected_reads(c), read_count - reads_before);
        check_value({name, " memory writes"}, expected_writes(c), write_count - writes_before);
        // Write-through leaves the stored word in memory
        if (c.op == dcache_pkg::OP_STORE) begin
            check_value({name, " memory word"}, c.wdata, peek_data);
        end
    endtask

    initial begin
        bit loaded;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        peek_addr = '0;
        read_cases(loaded);
        if (!loaded) begin
            $display("Could not read any access case from %s", CASE_FILE);
            $display("Simulation failed");
            $finish;
        end else begin
            cycle_limit = CYCLES_PER_CASE * cases.size() + RESET_CYCLES;
            repeat (RESET_CYCLES) @(posedge clk);
            #1;
            rst = 1'b0;
            foreach (cases[i]) begin
                run_case(i, cases[i]);
            end
            $display("Done: %0d cases, %0d errors", cases.size(), errors);
            if (errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim/line_memory_model.sv
// ====================
// Behavioural line memory
// Random latency, fixed fill pattern, read and write counters
// ====================
`timescale 1ns/100ps
`default_nettype none

module line_memory_model #(
    parameter int LINE_ADDR_WIDTH = 28,
    parameter int OFFSET_WIDTH    = 2
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic [LINE_ADDR_WIDTH-1:0]                            addr,
    input  wire logic                                                  read_enable,
    input  wire logic                                                  write_enable,
    input  wire logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]   write_line,
    output logic                                                       read_done,
    output logic                                                       write_done,
    output logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]        read_line,
    input  wire logic [LINE_ADDR_WIDTH+OFFSET_WIDTH-1:0]               peek_addr,
    output logic [dcache_pkg::WORD_WIDTH-1:0]                          peek_data,
    output int                                                         read_count,
    output int                                                         write_count
);

    localparam int WORD_WIDTH      = dcache_pkg::WORD_WIDTH;
    localparam int WORDS           = 2 ** OFFSET_WIDTH;
    localparam int WORD_ADDR_WIDTH = LINE_ADDR_WIDTH + OFFSET_WIDTH;

    // Only written words are stored, the rest follow the fill rule
    logic [WORD_WIDTH-1:0]       stored [logic [WORD_ADDR_WIDTH-1:0]];
    logic [31:0]                 lfsr = 32'h8f01_97f7;
    logic [2:0]                  delay_bits;
    logic [3:0]                  wait_left;
    logic                        pending;
    logic [WORDS*WORD_WIDTH-1:0] line_buf;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [WORD_WIDTH-1:0] word_at(input logic [WORD_ADDR_WIDTH-1:0] a);
        if (stored.exists(a)) begin
            return stored[a];
        end
        return WORD_WIDTH'(a) ^ 32'h5A5A_0000;
    endfunction

    always @(posedge clk) begin
        read_done  <= 1'b0;
        write_done <= 1'b0;
        if (rst) begin
            pending     <= 1'b0;
            wait_left   <= '0;
            read_line   <= '0;
            read_count  <= 0;
            write_count <= 0;
        end else if (read_done || write_done) begin
            // Enable is still high for this one cycle
            pending <= 1'b0;
        end else if (!pending && (read_enable || write_enable)) begin
            for (int b = 0; b < 3; b++) begin
                lfsr          = lfsr_step(lfsr);
                delay_bits[b] = lfsr[0];
            end
            pending   <= 1'b1;
            wait_left <= {1'b0, delay_bits} + 4'd1;
        end else if (pending) begin
            if (wait_left <= 4'd1) begin
                pending <= 1'b0;
                if (read_enable) begin
                    for (int w = 0; w < WORDS; w++) begin
                        line_buf[w*WORD_WIDTH +: WORD_WIDTH] = word_at({addr, OFFSET_WIDTH'(w)});
                    end
                    read_line  <= line_buf;
                    read_done  <= 1'b1;
                    read_count <= read_count + 1;
                end else begin
                    for (int w = 0; w < WORDS; w++) begin
                        stored[{addr, OFFSET_WIDTH'(w)}] = write_line[w*WORD_WIDTH +: WORD_WIDTH];
                    end
                    write_done  <= 1'b1;
                    write_count <= write_count + 1;
                end
            end else begin
                wait_left <= wait_left - 4'd1;
            end
        end
        peek_data <= word_at(peek_addr);
    end

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
// ====================
// Direct-mapped write-through data cache
// Controller, line replacer and array
// ====================
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  wire logic                 clk,
    input  wire logic                 rst,

    // CPU side
    input  wire logic                 req_valid,
    input  wire dcache_pkg::cpu_req_t req,
    output logic                      busy,
    output logic                      resp_valid,
    output dcache_pkg::cpu_resp_t     resp,

    // Line memory
    output logic [dcache_pkg::ADDR_WIDTH-OFFSET_WIDTH-3:0]           mem_addr,
    output logic                      mem_read_enable,
    output logic                      mem_write_enable,
    output logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]      mem_write_line,
    input  wire logic                 mem_read_done,
    input  wire logic                 mem_write_done,
    input  wire logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0] mem_read_line
);

    localparam int TAG_WIDTH       = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;
    localparam int LINE_WIDTH      = dcache_pkg::WORD_WIDTH * (2 ** OFFSET_WIDTH);
    localparam int LINE_ADDR_WIDTH = TAG_WIDTH + INDEX_WIDTH;

    // Array read port
    logic [INDEX_WIDTH-1:0]     read_index;
    logic                       read_valid;
    logic [TAG_WIDTH-1:0]       read_tag;
    logic [LINE_WIDTH-1:0]      read_line;

    // Muxed array write port
    logic                       write_enable;
    logic [INDEX_WIDTH-1:0]     write_index;
    logic                       write_valid;
    logic [TAG_WIDTH-1:0]       write_tag;
    logic [LINE_WIDTH-1:0]      write_line;

    // Replacer side of the write port
    logic                       repl_write_enable;
    logic                       repl_write_valid;
    logic [TAG_WIDTH-1:0]       repl_write_tag;
    logic [LINE_WIDTH-1:0]      repl_write_line;

    logic                       cmd_enable;
    dcache_pkg::cache_cmd_t     cmd;
    logic [LINE_ADDR_WIDTH-1:0] cmd_line_addr;
    logic                       cmd_done;

    dcache_controller #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) controller (
        .clk                (clk),
        .rst                (rst),
        .req_valid          (req_valid),
        .req                (req),
        .busy               (busy),
        .resp_valid         (resp_valid),
        .resp               (resp),
        .array_read_index   (read_index),
        .array_read_valid   (read_valid),
        .array_read_tag     (read_tag),
        .array_read_line    (read_line),
        .repl_write_enable  (repl_write_enable),
        .repl_write_valid   (repl_write_valid),
        .repl_write_tag     (repl_write_tag),
        .repl_write_line    (repl_write_line),
        .array_write_enable (write_enable),
        .array_write_index  (write_index),
        .array_write_valid  (write_valid),
        .array_write_tag    (write_tag),
        .array_write_line   (write_line),
        .cmd_enable         (cmd_enable),
        .cmd                (cmd),
        .cmd_line_addr      (cmd_line_addr),
        .cmd_done           (cmd_done)
    );

    dcache_replacer #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) replacer (
        .clk                (clk),
        .rst                (rst),
        .cmd_enable         (cmd_enable),
        .cmd                (cmd),
        .cmd_line_addr      (cmd_line_addr),
        .cmd_done           (cmd_done),
        .array_read_line    (read_line),
        .array_write_enable (repl_write_enable),
        .array_write_valid  (repl_write_valid),
        .array_write_tag    (repl_write_tag),
        .array_write_line   (repl_write_line),
        .mem_addr           (mem_addr),
        .mem_read_enable    (mem_read_enable),
        .mem_write_enable   (mem_write_enable),
        .mem_write_line     (mem_write_line),
        .mem_read_done      (mem_read_done),
        .mem_write_done     (mem_write_done),
        .mem_read_line      (mem_read_line)
    );

    dcache_array #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) array (
        .clk          (clk),
        .rst          (rst),
        .read_index   (read_index),
        .read_valid   (read_valid),
        .read_tag     (read_tag),
        .read_line    (read_line),
        .write_enable (write_enable),
        .write_index  (write_index),
        .write_valid  (write_valid),
        .write_tag    (write_tag),
        .write_line   (write_line)
    );

endmodule

`default_nettype wire

// File: verilog/dcache_controller.sv
// ====================
// Data cache controller
// CPU request handling, tag compare, store merge and
// command sequencing towards the line replacer
// ====================
`timescale 1ns/100ps
`default_nettype none

module dcache_controller #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  wire logic clk,
    input  wire logic rst,

    // CPU side
    input  wire logic                   req_valid,
    input  wire dcache_pkg::cpu_req_t   req,
    output logic                        busy,
    output logic                        resp_valid,
    output dcache_pkg::cpu_resp_t       resp,

    // Array read port
    output logic [INDEX_WIDTH-1:0]      array_read_index,
    input  wire logic                   array_read_valid,
    input  wire logic [dcache_pkg::ADDR_WIDTH-INDEX_WIDTH-OFFSET_WIDTH-3:0] array_read_tag,
    input  wire logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]        array_read_line,

    // Replacer write port, muxed with the store merge
    input  wire logic                   repl_write_enable,
    input  wire logic                   repl_write_valid,
    input  wire logic [dcache_pkg::ADDR_WIDTH-INDEX_WIDTH-OFFSET_WIDTH-3:0] repl_write_tag,
    input  wire logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]        repl_write_line,
    output logic                        array_write_enable,
    output logic [INDEX_WIDTH-1:0]      array_write_index,
    output logic                        array_write_valid,
    output logic [dcache_pkg::ADDR_WIDTH-INDEX_WIDTH-OFFSET_WIDTH-3:0] array_write_tag,
    output logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]        array_write_line,

    // Replacer command
    output logic                        cmd_enable,
    output dcache_pkg::cache_cmd_t      cmd,
    output logic [dcache_pkg::ADDR_WIDTH-OFFSET_WIDTH-3:0]             cmd_line_addr,
    input  wire logic                   cmd_done
);

    localparam int WORD_WIDTH = dcache_pkg::WORD_WIDTH;
    localparam int ADDR_WIDTH = dcache_pkg::ADDR_WIDTH;
    localparam int TAG_WIDTH  = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;
    localparam int LINE_WIDTH = WORD_WIDTH * (2 ** OFFSET_WIDTH);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_FILL,
        ST_FILLED,
        ST_FINISH
    } state_t;

    state_t                  state;
    dcache_pkg::cpu_req_t    req_q;
    logic                    hit_q;
    logic [TAG_WIDTH-1:0]    req_tag;
    logic [INDEX_WIDTH-1:0]  req_index;
    logic [OFFSET_WIDTH-1:0] req_offset;
    logic                    tag_hit;
    logic [WORD_WIDTH-1:0]   read_word;
    logic [LINE_WIDTH-1:0]   merged_line;
    logic                    ctrl_write_enable;
    logic                    accept;
    logic                    respond;

    always_comb begin
        req_tag     = req_q.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
        req_index   = req_q.addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
        req_offset  = req_q.addr[2 +: OFFSET_WIDTH];
        tag_hit     = array_read_valid && (array_read_tag == req_tag);
        read_word   = array_read_line[req_offset*WORD_WIDTH +: WORD_WIDTH];
        merged_line = array_read_line;
        merged_line[req_offset*WORD_WIDTH +: WORD_WIDTH] = req_q.wdata;
    end

    assign cmd_line_addr = req_q.addr[ADDR_WIDTH-1:OFFSET_WIDTH+2];

    // Commands go out from the compare cycle, or after a fill for a store
    always_comb begin
        cmd_enable = 1'b0;
        cmd        = dcache_pkg::CMD_WRITE_THROUGH;
        if (state == ST_COMPARE) begin
            case (req_q.op)
                dcache_pkg::OP_LOAD: begin
                    cmd_enable = !tag_hit;
                    cmd        = dcache_pkg::CMD_REPLACE;
                end
                dcache_pkg::OP_STORE: begin
                    cmd_enable = 1'b1;
                    if (!tag_hit) begin
                        cmd = dcache_pkg::CMD_REPLACE;
                    end
                end
                default: begin
                    cmd_enable = 1'b1;
                    cmd        = dcache_pkg::CMD_INVALIDATE;
                end
            endcase
        end else if (state == ST_FILLED) begin
            cmd_enable = (req_q.op == dcache_pkg::OP_STORE);
        end
    end

    // Store word lands in the array before the write-through reads it back
    assign ctrl_write_enable = (req_q.op == dcache_pkg::OP_STORE)
                            && ((state == ST_COMPARE && tag_hit) || state == ST_FILLED);

    // Replacer owns the write port whenever it writes
    always_comb begin
        array_read_index   = req_index;
        array_write_index  = req_index;
        array_write_enable = repl_write_enable || ctrl_write_enable;
        array_write_valid  = repl_write_enable ? repl_write_valid : 1'b1;
        array_write_tag    = repl_write_enable ? repl_write_tag : req_tag;
        array_write_line   = repl_write_enable ? repl_write_line : merged_line;
    end

    assign accept  = (state == ST_IDLE) && req_valid && !busy;
    assign respond = (req_q.op == dcache_pkg::OP_LOAD
                      && ((state == ST_COMPARE && tag_hit) || state == ST_FILLED))
                  || (state == ST_FINISH && cmd_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            busy       <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= respond;
            if (accept) begin
                busy <= 1'b1;
            end else if (resp_valid) begin
                busy <= 1'b0;
            end
            case (state)
                ST_IDLE:    if (accept) state <= ST_COMPARE;
                ST_COMPARE: begin
                    if (respond) begin
                        state <= ST_IDLE;
                    end else if (cmd == dcache_pkg::CMD_REPLACE) begin
                        state <= ST_FILL;
                    end else begin
                        state <= ST_FINISH;
                    end
                end
                ST_FILL:    if (cmd_done) state <= ST_FILLED;
                ST_FILLED:  state <= respond ? ST_IDLE : ST_FINISH;
                ST_FINISH:  if (cmd_done) state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        // Hit means the line was present at compare time
        if (state == ST_COMPARE) begin
            hit_q <= tag_hit;
        end
        if (respond) begin
            resp.rdata <= (req_q.op == dcache_pkg::OP_LOAD) ? read_word : '0;
            resp.hit   <= (state == ST_COMPARE) ? tag_hit : hit_q;
        end
    end

    resp_inside_busy: assert property (
        @(posedge clk) disable iff (rst)
        resp_valid |-> busy
    ) else $error("dcache_controller: response outside busy window");

endmodule

`default_nettype wire

// File: verilog/dcache_replacer.sv
// ====================
// Data cache line replacer
// Moves whole lines between the array and line memory for
// write-through, replace and invalidate commands
// ====================
`timescale 1ns/100ps
`default_nettype none

module dcache_replacer #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  wire logic clk,
    input  wire logic rst,

    // Command from the controller
    input  wire logic                   cmd_enable,
    input  wire dcache_pkg::cache_cmd_t cmd,
    input  wire logic [dcache_pkg::ADDR_WIDTH-OFFSET_WIDTH-3:0] cmd_line_addr,
    output logic                        cmd_done,

    // Array ports
    input  wire logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0] array_read_line,
    output logic                        array_write_enable,
    output logic                        array_write_valid,
    output logic [dcache_pkg::ADDR_WIDTH-INDEX_WIDTH-OFFSET_WIDTH-3:0] array_write_tag,
    output logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]        array_write_line,

    // Line memory
    output logic [dcache_pkg::ADDR_WIDTH-OFFSET_WIDTH-3:0]             mem_addr,
    output logic                        mem_read_enable,
    output logic                        mem_write_enable,
    output logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]        mem_write_line,
    input  wire logic                   mem_read_done,
    input  wire logic                   mem_write_done,
    input  wire logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]   mem_read_line
);

    localparam int TAG_WIDTH       = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;
    localparam int LINE_WIDTH      = dcache_pkg::WORD_WIDTH * (2 ** OFFSET_WIDTH);
    localparam int LINE_ADDR_WIDTH = TAG_WIDTH + INDEX_WIDTH;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_CACHE,
        ST_WRITE_MEM,
        ST_SETTLE,
        ST_READ_MEM,
        ST_WRITE_CACHE,
        ST_INVALIDATE
    } state_t;

    state_t                state;
    state_t                next_state;
    logic [LINE_WIDTH-1:0] line_q;

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (cmd_enable) begin
                    case (cmd)
                        dcache_pkg::CMD_WRITE_THROUGH: next_state = ST_READ_CACHE;
                        dcache_pkg::CMD_REPLACE:       next_state = ST_SETTLE;
                        default:                       next_state = ST_INVALIDATE;
                    endcase
                end
            end
            ST_READ_CACHE:  next_state = ST_WRITE_MEM;
            ST_WRITE_MEM:   next_state = mem_write_done ? ST_IDLE : ST_WRITE_MEM;
            ST_SETTLE:      next_state = ST_READ_MEM;
            ST_READ_MEM:    next_state = mem_read_done ? ST_WRITE_CACHE : ST_READ_MEM;
            ST_WRITE_CACHE: next_state = ST_IDLE;
            ST_INVALIDATE:  next_state = ST_IDLE;
            default:        next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Line buffer, from the array for write-through, from memory on a fill
    always_ff @(posedge clk) begin
        if (state == ST_READ_CACHE) begin
            line_q <= array_read_line;
        end else if (state == ST_READ_MEM && mem_read_done) begin
            line_q <= mem_read_line;
        end
    end

    // Tag half of the line address goes to the array, the index comes from
    // the controller's read port
    assign array_write_tag    = cmd_line_addr[LINE_ADDR_WIDTH-1:INDEX_WIDTH];
    assign array_write_enable = (state == ST_WRITE_CACHE) || (state == ST_INVALIDATE);
    assign array_write_valid  = (state == ST_WRITE_CACHE);
    assign array_write_line   = line_q;

    assign mem_addr         = cmd_line_addr;
    assign mem_read_enable  = (state == ST_READ_MEM);
    assign mem_write_enable = (state == ST_WRITE_MEM);
    assign mem_write_line   = line_q;

    assign cmd_done = (state == ST_WRITE_MEM && mem_write_done)
                   || (state == ST_WRITE_CACHE)
                   || (state == ST_INVALIDATE);

    cmd_only_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        cmd_enable |-> state == ST_IDLE
    ) else $error("dcache_replacer: command while busy");

    mem_enables_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(mem_read_enable && mem_write_enable)
    ) else $error("dcache_replacer: memory read and write together");

endmodule

`default_nettype wire

// File: verilog/dcache_array.sv
// ====================
// Data cache array
// Tag, valid and line storage, combinational read, clocked write
// ====================
`timescale 1ns/100ps
`default_nettype none

module dcache_array #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [INDEX_WIDTH-1:0] read_index,
    output logic                        read_valid,
    output logic [dcache_pkg::ADDR_WIDTH-INDEX_WIDTH-OFFSET_WIDTH-3:0] read_tag,
    output logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]        read_line,
    input  wire logic                   write_enable,
    input  wire logic [INDEX_WIDTH-1:0] write_index,
    input  wire logic                   write_valid,
    input  wire logic [dcache_pkg::ADDR_WIDTH-INDEX_WIDTH-OFFSET_WIDTH-3:0] write_tag,
    input  wire logic [dcache_pkg::WORD_WIDTH*(2**OFFSET_WIDTH)-1:0]        write_line
);

    localparam int TAG_WIDTH  = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;
    localparam int LINE_WIDTH = dcache_pkg::WORD_WIDTH * (2 ** OFFSET_WIDTH);
    localparam int LINES      = 2 ** INDEX_WIDTH;

    logic [LINE_WIDTH-1:0] line_mem [LINES];
    logic [TAG_WIDTH-1:0]  tag_mem [LINES];
    logic [LINES-1:0]      valid_bits;

    assign read_valid = valid_bits[read_index];
    assign read_tag   = tag_mem[read_index];
    assign read_line  = line_mem[read_index];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            line_mem[write_index] <= write_line;
            tag_mem[write_index]  <= write_tag;
        end
    end

    // Only the valid bits come out of reset cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (write_enable) begin
            valid_bits[write_index] <= write_valid;
        end
    end

    write_index_known: assert property (
        @(posedge clk) disable iff (rst)
        write_enable |-> !$isunknown(write_index)
    ) else $error("dcache_array: write with unknown index");

endmodule

`default_nettype wire

// File: verilog/dcache_pkg.sv
// ====================
// Data cache shared definitions
// Command, CPU operation and CPU request/response types
// ====================
`default_nettype none

package dcache_pkg;

    localparam int WORD_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;

    // Commands from the controller to the line replacer
    typedef enum logic [1:0] {
        CMD_WRITE_THROUGH = 2'd0,
        CMD_REPLACE       = 2'd1,
        CMD_INVALIDATE    = 2'd2
    } cache_cmd_t;

    // CPU access kinds
    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_FLUSH = 2'd2
    } cpu_op_t;

    // 66 bits: op, byte address, write data
    typedef struct packed {
        cpu_op_t                op;
        logic [ADDR_WIDTH-1:0]  addr;
        logic [WORD_WIDTH-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [WORD_WIDTH-1:0]  rdata;
        logic                   hit;
    } cpu_resp_t;

endpackage

`default_nettype wire
